//--- source/apb_pkg.sv
`default_nettype none

package apb_pkg;

	// One APB request as seen by the slave
	typedef struct packed {
		logic       select;
		logic       enable;
		logic       write;
		logic [7:0] addr;
		logic [7:0] wdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] rdata;
		logic       ready;
	} apb_rsp_t;

	// ********************
	// Register map
	// ********************
	localparam logic [7:0] REG_NBY  = 8'h00;
	localparam logic [7:0] REG_ADR  = 8'h04;
	localparam logic [7:0] REG_RDR0 = 8'h08;
	localparam logic [7:0] REG_RDR1 = 8'h09;
	localparam logic [7:0] REG_RDR2 = 8'h0A;
	localparam logic [7:0] REG_RDR3 = 8'h0B;
	localparam logic [7:0] REG_TDR0 = 8'h0C;
	localparam logic [7:0] REG_TDR1 = 8'h0D;
	localparam logic [7:0] REG_TDR2 = 8'h0E;
	localparam logic [7:0] REG_TDR3 = 8'h0F;
	localparam logic [7:0] REG_CFG  = 8'h10;

endpackage

`default_nettype wire

//--- source/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// Transaction request from the register bank
	typedef struct packed {
		logic        start;
		logic        read;
		logic [6:0]  addr;
		logic [1:0]  nby;
		logic [31:0] tdata;
	} i2c_cmd_t;

	// Engine feedback
	typedef struct packed {
		logic       busy;
		logic       done;
		logic       nack;
		logic       rbyte_we;
		logic [1:0] rbyte_idx;
		logic [7:0] rbyte;
	} i2c_stat_t;

	// ********************
	// CFG register bits
	// ********************
	localparam int CFG_GO_WR   = 0;
	localparam int CFG_DONE_WR = 1;
	localparam int CFG_GO_RD   = 2;
	localparam int CFG_DONE_RD = 3;
	localparam int CFG_NACK    = 4;

	// System clocks per quarter of an I2C bit
	localparam int I2C_CLK_DIV = 4;
	localparam int I2C_DIV_W   = $clog2(I2C_CLK_DIV);

	typedef enum logic [2:0] {
		IDLE,
		START,
		ADDR,
		ACK0,
		WDATA,
		RDATA,
		ACK1,
		STOP
	} i2c_state_t;

endpackage

`default_nettype wire

//--- source/i2c_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_reg_file (
	input  wire               clk_i,
	input  wire               rst,
	input  apb_pkg::apb_req_t apb_req_i,
	output apb_pkg::apb_rsp_t apb_rsp_o,
	input  i2c_pkg::i2c_stat_t stat_i,
	output i2c_pkg::i2c_cmd_t cmd_o
);

	import apb_pkg::*;
	import i2c_pkg::*;

	logic              setup;
	logic              cfg_wr;
	logic              go_ok;
	logic              eng_busy;
	logic [1:0]        nby_q;
	logic [6:0]        adr_q;
	logic [31:0]       tdr_q;
	logic [31:0]       rdr_q;
	logic [CFG_NACK:0] cfg_q;
	logic [7:0]        rdata_q;
	logic [7:0]        rd_mux;
	logic              start_q;

	assign setup    = apb_req_i.select & ~apb_req_i.enable;
	assign eng_busy = stat_i.busy | start_q;
	assign cfg_wr   = setup & apb_req_i.write & (apb_req_i.addr == REG_CFG);

	// Exactly one go bit, engine idle
	assign go_ok = cfg_wr & ~eng_busy
		& (apb_req_i.wdata[CFG_GO_WR] ^ apb_req_i.wdata[CFG_GO_RD]);

	// ********************
	// Read multiplexer
	// ********************
	always_comb begin
		rd_mux = '0;
		case (apb_req_i.addr)
			REG_NBY:  rd_mux = {6'b0, nby_q};
			REG_ADR:  rd_mux = {1'b0, adr_q};
			REG_RDR0: rd_mux = rdr_q[7:0];
			REG_RDR1: rd_mux = rdr_q[15:8];
			REG_RDR2: rd_mux = rdr_q[23:16];
			REG_RDR3: rd_mux = rdr_q[31:24];
			REG_TDR0: rd_mux = tdr_q[7:0];
			REG_TDR1: rd_mux = tdr_q[15:8];
			REG_TDR2: rd_mux = tdr_q[23:16];
			REG_TDR3: rd_mux = tdr_q[31:24];
			REG_CFG:  rd_mux = {3'b0, cfg_q};
			default:  rd_mux = '0;
		endcase
	end

	// ********************
	// Register bank
	// ********************
	always_ff @(posedge clk_i) begin
		if (rst) begin
			nby_q   <= '0;
			adr_q   <= '0;
			tdr_q   <= '0;
			rdr_q   <= '0;
			cfg_q   <= '0;
			rdata_q <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= go_ok;

			if (setup && !apb_req_i.write)
				rdata_q <= rd_mux;

			if (setup && apb_req_i.write) begin
				case (apb_req_i.addr)
					REG_NBY:  nby_q         <= apb_req_i.wdata[1:0];
					REG_ADR:  adr_q         <= apb_req_i.wdata[6:0];
					REG_TDR0: tdr_q[7:0]    <= apb_req_i.wdata;
					REG_TDR1: tdr_q[15:8]   <= apb_req_i.wdata;
					REG_TDR2: tdr_q[23:16]  <= apb_req_i.wdata;
					REG_TDR3: tdr_q[31:24]  <= apb_req_i.wdata;
					default: ;
				endcase
			end

			// Received bytes land by slot
			if (stat_i.rbyte_we)
				rdr_q[8*stat_i.rbyte_idx +: 8] <= stat_i.rbyte;

			// New command clears old status
			if (cfg_wr && !eng_busy) begin
				cfg_q <= '0;
				if (go_ok) begin
					cfg_q[CFG_GO_WR] <= apb_req_i.wdata[CFG_GO_WR];
					cfg_q[CFG_GO_RD] <= apb_req_i.wdata[CFG_GO_RD];
				end
			end else if (stat_i.done) begin
				cfg_q[CFG_GO_WR]   <= 1'b0;
				cfg_q[CFG_GO_RD]   <= 1'b0;
				cfg_q[CFG_DONE_WR] <= cfg_q[CFG_GO_WR];
				cfg_q[CFG_DONE_RD] <= cfg_q[CFG_GO_RD];
				if (stat_i.nack)
					cfg_q[CFG_NACK] <= 1'b1;
			end
		end
	end

	// No wait states; idle level outside a transfer
	assign apb_rsp_o.rdata = rdata_q;
	assign apb_rsp_o.ready = apb_req_i.select ? apb_req_i.enable : ~eng_busy;

	assign cmd_o.start = start_q;
	assign cmd_o.read  = cfg_q[CFG_GO_RD];
	assign cmd_o.addr  = adr_q;
	assign cmd_o.nby   = nby_q;
	assign cmd_o.tdata = tdr_q;

endmodule

`default_nettype wire

//--- source/i2c_clk_div.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_clk_div (
	input  wire  clk_i,
	input  wire  rst,
	input  wire  en_i,
	output logic tick_o
);

	import i2c_pkg::*;

	logic [I2C_DIV_W-1:0] cnt_q;

	// Count restarts whenever the engine is idle
	always_ff @(posedge clk_i) begin
		if (rst || !en_i) begin
			cnt_q <= '0;
		end else if (cnt_q == I2C_DIV_W'(I2C_CLK_DIV - 1)) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// Quarter-bit strobe
	assign tick_o = en_i && (cnt_q == I2C_DIV_W'(I2C_CLK_DIV - 1));

endmodule

`default_nettype wire

//--- source/i2c_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine (
	input  wire                clk_i,
	input  wire                rst,
	input  wire                tick_i,
	input  i2c_pkg::i2c_cmd_t  cmd_i,
	input  wire                sda_i,
	output i2c_pkg::i2c_stat_t stat_o,
	output logic               scl_oe_o,
	output logic               sda_oe_o
);

	import i2c_pkg::*;

	i2c_state_t  state;
	logic [1:0]  q_cnt;
	logic [2:0]  bit_cnt;
	logic [1:0]  byte_cnt;
	logic        nack_q;
	logic        rbyte_we_q;
	logic        sda_pull;
	logic        sample;
	logic        bit_end;
	logic        rd_q;
	logic [6:0]  addr_q;
	logic [1:0]  nby_q;
	logic [31:0] tdata_q;
	logic [7:0]  rx_sr;

	assign sample  = tick_i && (q_cnt == 2'd2);
	assign bit_end = tick_i && (q_cnt == 2'd3);

	// ********************
	// Bit sequencer
	// ********************
	always_ff @(posedge clk_i) begin
		if (rst) begin
			state      <= IDLE;
			q_cnt      <= '0;
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			nack_q     <= 1'b0;
			rbyte_we_q <= 1'b0;
			sda_oe_o   <= 1'b0;
		end else begin
			// SDA follows SCL by one clock
			sda_oe_o   <= sda_pull;
			rbyte_we_q <= sample && (state == RDATA) && (bit_cnt == 3'd0);

			if (state == IDLE) begin
				if (cmd_i.start) begin
					state  <= START;
					q_cnt  <= '0;
					nack_q <= 1'b0;
				end
			end else if (tick_i) begin
				q_cnt <= q_cnt + 2'd1;
			end

			if (sample && state == ACK0)
				nack_q <= sda_i;

			if (bit_end) begin
				case (state)
					START: begin
						state   <= ADDR;
						bit_cnt <= 3'd7;
					end
					ADDR, WDATA, RDATA: begin
						if (bit_cnt == 3'd0)
							state <= (state == ADDR) ? ACK0 : ACK1;
						else
							bit_cnt <= bit_cnt - 3'd1;
					end
					ACK0: begin
						// Address not acknowledged
						if (nack_q) begin
							state <= STOP;
						end else begin
							state    <= rd_q ? RDATA : WDATA;
							bit_cnt  <= 3'd7;
							byte_cnt <= '0;
						end
					end
					ACK1: begin
						if (byte_cnt == nby_q) begin
							state <= STOP;
						end else begin
							state    <= rd_q ? RDATA : WDATA;
							bit_cnt  <= 3'd7;
							byte_cnt <= byte_cnt + 2'd1;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// Command latch and receive shifter
	always_ff @(posedge clk_i) begin
		if (state == IDLE && cmd_i.start) begin
			rd_q    <= cmd_i.read;
			addr_q  <= cmd_i.addr;
			nby_q   <= cmd_i.nby;
			tdata_q <= cmd_i.tdata;
		end
		if (sample && state == RDATA)
			rx_sr <= {rx_sr[6:0], sda_i};
	end

	// ********************
	// Line drivers
	// ********************
	always_comb begin
		case (state)
			START:   sda_pull = q_cnt[1];
			ADDR:    sda_pull = ~(bit_cnt == 3'd0 ? rd_q : addr_q[bit_cnt - 3'd1]);
			WDATA:   sda_pull = ~tdata_q[{byte_cnt, bit_cnt}];
			// ACK all but the last read byte
			ACK1:    sda_pull = rd_q && (byte_cnt != nby_q);
			STOP:    sda_pull = (q_cnt != 2'd3);
			default: sda_pull = 1'b0;
		endcase
	end

	// SCL low in the first half of every bit after START
	assign scl_oe_o = !q_cnt[1] && (state != IDLE) && (state != START);

	assign stat_o.busy      = (state != IDLE);
	assign stat_o.done      = bit_end && (state == STOP);
	assign stat_o.nack      = nack_q;
	assign stat_o.rbyte_we  = rbyte_we_q;
	assign stat_o.rbyte_idx = byte_cnt;
	assign stat_o.rbyte     = rx_sr;

endmodule

`default_nettype wire

//--- source/i2c_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
	input  wire               clk_i,
	input  wire               rst,
	input  apb_pkg::apb_req_t apb_req_i,
	output apb_pkg::apb_rsp_t apb_rsp_o,
	input  wire               sda_i,
	output logic              scl_oe_o,
	output logic              sda_oe_o
);

	import i2c_pkg::*;

	i2c_cmd_t  cmd;
	i2c_stat_t stat;
	logic      tick;

	i2c_reg_file u_reg (
		.clk_i     (clk_i),
		.rst       (rst),
		.apb_req_i (apb_req_i),
		.apb_rsp_o (apb_rsp_o),
		.stat_i    (stat),
		.cmd_o     (cmd)
	);

	// Quarter-bit timing runs only while busy
	i2c_clk_div u_div (
		.clk_i  (clk_i),
		.rst    (rst),
		.en_i   (stat.busy),
		.tick_o (tick)
	);

	i2c_byte_engine u_eng (
		.clk_i    (clk_i),
		.rst      (rst),
		.tick_i   (tick),
		.cmd_i    (cmd),
		.sda_i    (sda_i),
		.stat_o   (stat),
		.scl_oe_o (scl_oe_o),
		.sda_oe_o (sda_oe_o)
	);

endmodule

`default_nettype wire

//--- sim/i2c_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
	parameter logic [6:0] SLV_ADDR = 7'h00
) (
	input  wire  scl_i,
	input  wire  sda_i,
	output logic sda_oe_o
);

	logic [7:0] rd_mem [4];
	logic [7:0] wr_bytes [8];
	logic       ack_bits [8];
	logic [7:0] addr_byte;
	logic [7:0] sr;
	logic       active;
	logic       selected;
	logic       rw;
	logic       in_data;
	int         bit_cnt;
	int         rd_idx;
	int         wr_cnt;
	int         data_cnt;
	int         ack_cnt;
	int         stop_cnt;

	initial begin
		sda_oe_o  = 1'b0;
		active    = 1'b0;
		selected  = 1'b0;
		rw        = 1'b0;
		in_data   = 1'b0;
		sr        = '0;
		addr_byte = '0;
		bit_cnt   = 0;
		rd_idx    = 0;
		wr_cnt    = 0;
		data_cnt  = 0;
		ack_cnt   = 0;
		stop_cnt  = 0;
	end

	task automatic clear_log();
		wr_cnt    = 0;
		data_cnt  = 0;
		ack_cnt   = 0;
		stop_cnt  = 0;
		addr_byte = '0;
	endtask

	task automatic load_byte(input int idx, input logic [7:0] val);
		rd_mem[idx] = val;
	endtask

	// START condition
	always @(negedge sda_i) begin
		if (scl_i === 1'b1 && sda_i === 1'b0) begin
			active   = 1'b1;
			selected = 1'b0;
			in_data  = 1'b0;
			bit_cnt  = -1;
			sda_oe_o = 1'b0;
		end
	end

	// STOP condition
	always @(posedge sda_i) begin
		if (scl_i === 1'b1 && sda_i === 1'b1 && active) begin
			active   = 1'b0;
			selected = 1'b0;
			sda_oe_o = 1'b0;
			stop_cnt++;
		end
	end

	always @(posedge scl_i) begin
		if (active) begin
			if (bit_cnt >= 0 && bit_cnt < 8) begin
				sr = {sr[6:0], sda_i};
			end else if (bit_cnt == 8 && selected && rw && in_data && ack_cnt < 8) begin
				ack_bits[ack_cnt] = sda_i;
				ack_cnt++;
			end
		end
	end

	// ********************
	// Drive on falling SCL
	// ********************
	always @(negedge scl_i) begin
		if (active) begin
			bit_cnt++;
			if (bit_cnt == 8) begin
				// Any byte on the bus after the address
				if (in_data)
					data_cnt++;
				if (!in_data) begin
					addr_byte = sr;
					selected  = (sr[7:1] == SLV_ADDR);
					rw        = sr[0];
					sda_oe_o  = selected;
				end else if (selected && !rw) begin
					if (wr_cnt < 8)
						wr_bytes[wr_cnt] = sr;
					wr_cnt++;
					sda_oe_o = 1'b1;
				end else begin
					sda_oe_o = 1'b0;
				end
			end else if (bit_cnt == 9) begin
				bit_cnt  = 0;
				sda_oe_o = 1'b0;
				if (selected && rw) begin
					if (!in_data)
						rd_idx = 0;
					else if (ack_cnt > 0 && ack_bits[ack_cnt - 1])
						selected = 1'b0;
					else
						rd_idx++;
					if (selected)
						sda_oe_o = ~rd_mem[rd_idx % 4][7];
				end
				in_data = 1'b1;
			end else if (selected && rw && in_data) begin
				sda_oe_o = ~rd_mem[rd_idx % 4][7 - bit_cnt];
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/i2c_master_chk.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_chk (
	input wire               clk_i,
	input wire               rst,
	input apb_pkg::apb_req_t apb_req_i,
	input apb_pkg::apb_rsp_t apb_rsp_i,
	input wire               scl_oe_i,
	input wire               sda_oe_i,
	input wire               busy_i
);

	logic scl_hi;

	assign scl_hi = !scl_oe_i;

	// Only a START pulls SDA under a long high SCL
	a_sda_rise: assert property (@(posedge clk_i) disable iff (rst)
		($rose(sda_oe_i) && scl_hi) |-> ($past(scl_hi, 5) && $past(scl_hi, 10)))
		else $error("SDA pulled low while SCL high outside START");

	a_ready: assert property (@(posedge clk_i) disable iff (rst)
		(apb_req_i.select && apb_req_i.enable) |-> apb_rsp_i.ready)
		else $error("APB ready low in access cycle");

	a_rst_idle: assert property (@(posedge clk_i)
		(rst && $past(rst)) |-> (!scl_oe_i && !sda_oe_i))
		else $error("Line enables active during reset");

	// Release under high SCL is the STOP, engine idles soon after
	a_sda_release: assert property (@(posedge clk_i) disable iff (rst)
		($fell(sda_oe_i) && scl_hi) |-> ##3 !busy_i)
		else $error("SDA released in the middle of a bit");

endmodule

bind i2c_master_top i2c_master_chk chk0 (
	.clk_i     (clk_i),
	.rst       (rst),
	.apb_req_i (apb_req_i),
	.apb_rsp_i (apb_rsp_o),
	.scl_oe_i  (scl_oe_o),
	.sda_oe_i  (sda_oe_o),
	.busy_i    (stat.busy)
);

`default_nettype wire

//--- sim/tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

	import apb_pkg::*;
	import i2c_pkg::*;

	localparam logic [6:0] SLV_ADDR = 7'h52;
	localparam int N_XFER  = 30;
	localparam int MAX_CYC = 40 * 47 * 4 * I2C_CLK_DIV + 2000;

	logic     clk_i;
	logic     rst;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     scl_oe;
	logic     sda_oe;
	logic     slv_sda_oe;
	wire      scl_line;
	wire      sda_line;
	int       err_cnt = 0;
	int       chk_cnt = 0;
	int       cyc_cnt = 0;

	// Reference model of the register bank
	logic [1:0] m_nby;
	logic [6:0] m_adr;
	logic [7:0] m_tdr [4];
	logic [7:0] m_rdr [4];
	logic [7:0] m_cfg;

	// Wired-AND of both pull-downs
	assign scl_line = ~scl_oe;
	assign sda_line = ~(sda_oe | slv_sda_oe);

	i2c_master_top dut0 (
		.clk_i     (clk_i),
		.rst       (rst),
		.apb_req_i (apb_req),
		.apb_rsp_o (apb_rsp),
		.sda_i     (sda_line),
		.scl_oe_o  (scl_oe),
		.sda_oe_o  (sda_oe)
	);

	i2c_slave_model #(.SLV_ADDR(SLV_ADDR)) slv0 (
		.scl_i    (scl_line),
		.sda_i    (sda_line),
		.sda_oe_o (slv_sda_oe)
	);

	initial clk_i = 1'b0;
	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= MAX_CYC) begin
			$display("Timeout: run did not finish within %0d clock cycles", MAX_CYC);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// ********************
	// APB transfers
	// ********************
	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk_i);
		apb_req.select <= 1'b1;
		apb_req.enable <= 1'b0;
		apb_req.write  <= 1'b1;
		apb_req.addr   <= addr;
		apb_req.wdata  <= data;
		@(posedge clk_i);
		apb_req.enable <= 1'b1;
		@(negedge clk_i);
		check_val("apb_rsp.ready", 32'(apb_rsp.ready), 32'd1);
		@(posedge clk_i);
		apb_req <= '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [7:0] data);
		@(posedge clk_i);
		apb_req.select <= 1'b1;
		apb_req.enable <= 1'b0;
		apb_req.write  <= 1'b0;
		apb_req.addr   <= addr;
		apb_req.wdata  <= '0;
		@(posedge clk_i);
		apb_req.enable <= 1'b1;
		@(negedge clk_i);
		check_val("apb_rsp.ready", 32'(apb_rsp.ready), 32'd1);
		data = apb_rsp.rdata;
		@(posedge clk_i);
		apb_req <= '0;
	endtask

	task automatic check_regs();
		logic [7:0] v;
		apb_read(REG_NBY, v);
		check_val("NBY", 32'(v), 32'(m_nby));
		apb_read(REG_ADR, v);
		check_val("ADR", 32'(v), 32'(m_adr));
		for (int i = 0; i < 4; i++) begin
			apb_read(REG_TDR0 + 8'(i), v);
			check_val($sformatf("TDR%0d", i), 32'(v), 32'(m_tdr[i]));
			apb_read(REG_RDR0 + 8'(i), v);
			check_val($sformatf("RDR%0d", i), 32'(v), 32'(m_rdr[i]));
		end
		apb_read(REG_CFG, v);
		check_val("CFG", 32'(v), 32'(m_cfg));
	endtask

	task automatic write_random_regs();
		logic [7:0] v;
		v = 8'($urandom);
		apb_write(REG_NBY, v);
		m_nby = v[1:0];
		v = 8'($urandom);
		apb_write(REG_ADR, v);
		m_adr = v[6:0];
		for (int i = 0; i < 4; i++) begin
			v = 8'($urandom);
			apb_write(REG_TDR0 + 8'(i), v);
			m_tdr[i] = v;
		end
	endtask

	task automatic wait_done(input int bit_pos);
		logic [7:0] v;
		v = '0;
		while (v[bit_pos] !== 1'b1)
			apb_read(REG_CFG, v);
	endtask

	// ********************
	// One I2C transaction
	// ********************
	task automatic run_xfer(input logic rd, input logic [6:0] adr, input logic busy_go);
		logic [7:0] go_val;
		logic [7:0] other_val;
		logic [7:0] exp_rd [4];
		logic       nack;
		write_random_regs();
		apb_write(REG_ADR, {1'b0, adr});
		m_adr = adr;
		for (int i = 0; i < 4; i++) begin
			exp_rd[i] = 8'($urandom);
			slv0.load_byte(i, exp_rd[i]);
		end
		slv0.clear_log();
		go_val = '0;
		go_val[rd ? CFG_GO_RD : CFG_GO_WR] = 1'b1;
		other_val = '0;
		other_val[rd ? CFG_GO_WR : CFG_GO_RD] = 1'b1;
		apb_write(REG_CFG, go_val);
		// Engine busy, must be dropped
		if (busy_go)
			apb_write(REG_CFG, other_val);
		wait_done(rd ? CFG_DONE_RD : CFG_DONE_WR);

		nack = (adr != SLV_ADDR);
		m_cfg = '0;
		m_cfg[rd ? CFG_DONE_RD : CFG_DONE_WR] = 1'b1;
		if (nack)
			m_cfg[CFG_NACK] = 1'b1;
		if (rd && !nack) begin
			for (int i = 0; i <= int'(m_nby); i++)
				m_rdr[i] = exp_rd[i];
		end

		check_val("slave stop count", slv0.stop_cnt, 32'd1);
		check_val("slave address byte", 32'(slv0.addr_byte), 32'({adr, rd}));
		if (nack) begin
			check_val("slave data byte count", slv0.data_cnt, 32'd0);
			check_val("slave ack count", slv0.ack_cnt, 32'd0);
		end else if (!rd) begin
			check_val("slave write count", slv0.wr_cnt, 32'(int'(m_nby) + 1));
			for (int i = 0; i <= int'(m_nby); i++)
				check_val($sformatf("slave byte %0d", i), 32'(slv0.wr_bytes[i]),
					32'(m_tdr[i]));
			check_val("slave ack count", slv0.ack_cnt, 32'd0);
		end else begin
			check_val("master ack count", slv0.ack_cnt, 32'(int'(m_nby) + 1));
			for (int i = 0; i <= int'(m_nby); i++)
				check_val($sformatf("master ack %0d", i), 32'(slv0.ack_bits[i]),
					32'(i == int'(m_nby)));
		end
		check_regs();
	endtask

	initial begin
		logic [6:0] bad_adr;
		rst     = 1'b1;
		apb_req = '0;
		m_nby   = '0;
		m_adr   = '0;
		m_cfg   = '0;
		for (int i = 0; i < 4; i++) begin
			m_tdr[i] = '0;
			m_rdr[i] = '0;
		end
		void'($urandom(3));
		repeat (3) @(posedge clk_i);
		rst <= 1'b0;

		check_regs();
		repeat (4) begin
			write_random_regs();
			check_regs();
		end

		for (int n = 0; n < N_XFER; n++)
			run_xfer(1'($urandom), SLV_ADDR, 1'b0);

		// Wrong address, both directions
		for (int n = 0; n < 4; n++) begin
			bad_adr = SLV_ADDR ^ 7'(32'd1 + $urandom % 32'd127);
			run_xfer(1'(n % 2), bad_adr, 1'b0);
		end

		run_xfer(1'b0, SLV_ADDR, 1'b1);
		run_xfer(1'b1, SLV_ADDR, 1'b1);

		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
source/apb_pkg.sv
source/i2c_pkg.sv
source/i2c_reg_file.sv
source/i2c_clk_div.sv
source/i2c_byte_engine.sv
source/i2c_master_top.sv
sim/i2c_slave_model.sv
sim/i2c_master_chk.sv
sim/tb_i2c_master.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_i2c_master
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
